// ==== verification/rename_testdata.txt ====
# rep valid rs1 rs2 rd writes_rd ckpt recover label free_valid free_preg release, then expected stall ooc pdst
# all hex, rep repeats the line, pdst ff is not checked against this file
1 1 03 07 05 1 0 0 0 0 00 0 0 0 20
1 1 05 00 06 1 0 0 0 0 00 0 0 0 21
1 1 06 05 05 1 0 0 0 0 00 0 0 0 22
1 1 01 02 00 1 0 0 0 0 00 0 0 0 00
1 1 06 06 06 0 0 0 0 0 00 0 0 0 21
1 1 07 00 07 1 0 0 0 0 00 0 0 0 23
1 1 05 07 08 1 1 0 0 0 00 0 0 0 24
1 1 08 05 05 1 0 0 0 0 00 0 0 0 25
1 1 09 08 09 1 0 0 0 0 00 0 0 0 26
1 0 00 00 00 0 0 1 0 0 00 0 0 0 ff
1 1 05 08 09 1 0 0 0 0 00 0 1 0 ff
1 1 05 08 09 1 0 0 0 0 00 0 0 0 24
3 1 01 02 00 0 1 0 0 0 00 0 0 0 ff
1 1 01 02 00 0 1 0 0 0 00 0 1 1 ff
1 0 00 00 00 0 0 0 0 0 00 1 0 1 ff
1 1 05 09 0a 1 1 0 0 0 00 0 0 0 25
1 0 00 00 00 0 0 1 1 0 00 0 0 1 ff
1 0 00 00 00 0 0 0 0 0 00 0 0 0 ff
1b 1 00 00 0b 1 0 0 0 0 00 0 0 0 ff
1 1 00 00 0c 1 0 0 0 0 00 0 1 0 ff
1 0 00 00 00 0 0 0 0 1 14 0 0 0 ff
1 1 0c 0b 0c 1 0 0 0 0 00 0 0 0 14
1 1 00 00 0d 1 0 0 0 0 00 0 1 0 ff

// ==== tb.f ====
+incdir+source
source/isa_pkg.sv
source/rename_pkg.sv
source/rename_request.sv
source/free_list.sv
source/rename_table.sv
source/rename_top.sv
verification/tb_rename_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -f tb.f --top-module tb_rename_top

# The simulator exits nonzero on failure, the grep decides the result
out=$(./obj_dir/Vtb_rename_top 2>&1) || true
echo "$out"
echo "$out" | grep -qx "Testbench passed"

// ==== verification/tb_rename_top.sv ====
// Testbench that replays the testdata file through the rename stage against a reference model
`timescale 1ns/1ps
`default_nettype none
`include "rename_params.svh"

module tb_rename_top
    import isa_pkg::*, rename_pkg::*;
();

    localparam int NUM_ARCH  = `RENAME_NUM_ARCH_REGS;
    localparam int NUM_PHYS  = `RENAME_NUM_PHYS_REGS;
    localparam int NUM_CKPT  = `RENAME_NUM_CHECKPOINTS;
    localparam int FL_DEPTH  = NUM_PHYS - NUM_ARCH;
    localparam int MAX_WAIT  = 8;     // Cycles before a missing out_valid_o counts as hung
    localparam int MAX_LINES = 1000;  // Runaway guard on the data file
    localparam int NO_CHECK  = 255;   // pdst column value that skips the check

    logic           clk;
    logic           rstn;
    rename_req_t    req;
    logic           checkpoint_req;
    logic           recover;
    checkpoint_t    recover_label;
    logic           free_valid;
    phys_reg_t      free_preg;
    logic           release_ckpt;
    renamed_instr_t renamed;
    logic           out_valid;
    logic           rename_stall;
    logic           out_of_ckpt;

    // Reference model
    int map_m [NUM_CKPT][NUM_ARCH];  // One map per version
    int fl_m [FL_DEPTH];
    int snap_m [NUM_CKPT];           // Free-list head saved per label
    int ver_head;                    // Working version
    int ver_tail;                    // Oldest live checkpoint
    int live_ckpt;
    int fl_head;                     // Counters only grow and wrap by modulo
    int fl_tail;
    bit pending;                     // Cycle after a recover

    // Expectations for the cycle being applied
    bit             exp_stall;
    bit             exp_valid;
    bit             exp_alloc;
    bit             exp_ckpt;
    renamed_instr_t exp_out;

    rename_top uut (
        .clk_i                (clk),
        .rstn_i               (rstn),
        .req_i                (req),
        .checkpoint_req_i     (checkpoint_req),
        .recover_i            (recover),
        .recover_label_i      (recover_label),
        .free_valid_i         (free_valid),
        .free_preg_i          (free_preg),
        .release_checkpoint_i (release_ckpt),
        .renamed_o            (renamed),
        .out_valid_o          (out_valid),
        .rename_stall_o       (rename_stall),
        .out_of_checkpoints_o (out_of_ckpt)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;  // 40 ns period

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("Error at %0t ns: %s", $time, why);
        $display("Testbench failed");
        $fatal(1, "run aborted");
    endtask

    // Identity map everywhere and p32..p63 free in order
    task automatic reset_model();
        for (int v = 0; v < NUM_CKPT; v++) begin
            snap_m[v] = 0;
            for (int r = 0; r < NUM_ARCH; r++) begin
                map_m[v][r] = r;
            end
        end
        for (int i = 0; i < FL_DEPTH; i++) begin
            fl_m[i] = NUM_ARCH + i;
        end
        ver_head  = 0;
        ver_tail  = 0;
        live_ckpt = 0;
        fl_head   = 0;
        fl_tail   = FL_DEPTH;
        pending   = 1'b0;
    endtask

    // Stall decision and renamed fields from the model before the edge
    task automatic predict();
        bit needs_alloc;
        bit go;
        int dst_map;
        needs_alloc = req.valid && req.writes_rd && (req.rd != '0);  // x0 never renamed
        exp_stall   = !recover && ((needs_alloc && (fl_tail == fl_head))
                      || (checkpoint_req && (live_ckpt == NUM_CKPT - 1))
                      || (pending && (req.valid || checkpoint_req)));
        go          = !recover && !pending && !exp_stall;
        exp_valid   = req.valid && go;
        exp_alloc   = needs_alloc && go;
        exp_ckpt    = checkpoint_req && req.valid && go;
        dst_map     = map_m[ver_head][req.rd];
        exp_out.prs1           = phys_reg_t'(map_m[ver_head][req.rs1]);  // Old mapping
        exp_out.prs2           = phys_reg_t'(map_m[ver_head][req.rs2]);
        exp_out.pdst           = phys_reg_t'(exp_alloc ? fl_m[fl_head % FL_DEPTH] : dst_map);
        exp_out.old_pdst       = phys_reg_t'(dst_map);
        exp_out.checkpoint     = checkpoint_t'(ver_head);  // Frozen version is the label
        exp_out.has_checkpoint = exp_ckpt;
    endtask

    // Model state change at the rising edge
    task automatic advance_model();
        bit release_en;
        int next_ver;
        release_en = release_ckpt && (live_ckpt != 0);
        if (release_en) begin
            ver_tail = (ver_tail + 1) % NUM_CKPT;
        end
        if (free_valid) begin
            fl_m[fl_tail % FL_DEPTH] = int'(free_preg);  // Commit push happens during recover too
            fl_tail++;
        end
        if (recover) begin
            ver_head  = int'(recover_label);
            fl_head   = snap_m[ver_head];
            live_ckpt = (ver_head - ver_tail + NUM_CKPT) % NUM_CKPT;
        end else begin
            if (release_en) begin
                live_ckpt--;
            end
            if (exp_ckpt) begin
                next_ver = (ver_head + 1) % NUM_CKPT;
                snap_m[ver_head] = fl_head;  // Head before own allocation
                for (int r = 0; r < NUM_ARCH; r++) begin
                    map_m[next_ver][r] = map_m[ver_head][r];
                end
                ver_head = next_ver;
                live_ckpt++;
            end
            if (exp_alloc) begin
                map_m[ver_head][req.rd] = fl_m[fl_head % FL_DEPTH];
                fl_head++;
            end
        end
        pending = recover;
    endtask

    // One checked clock that starts and ends 2 ns after a rising edge
    task automatic run_cycle(input int file_stall, input int file_ooc, input int file_pdst);
        int waited;
        predict();
        #5;  // Combinational stall settled
        check_value(int'(rename_stall), int'(exp_stall), "rename_stall_o vs model");
        check_value(int'(rename_stall), file_stall, "rename_stall_o vs data file");
        check_value(int'(out_of_ckpt), int'(live_ckpt == NUM_CKPT - 1),
                    "out_of_checkpoints_o vs model");
        check_value(int'(out_of_ckpt), file_ooc, "out_of_checkpoints_o vs data file");
        @(posedge clk);
        advance_model();
        #1;
        if (exp_valid) begin
            waited = 0;
            while (!out_valid && (waited < MAX_WAIT)) begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (!out_valid) begin
                abort_run("timeout waiting for out_valid_o");
            end
            check_value(waited, 0, "extra cycles of rename latency");
            check_value(int'(renamed.prs1), int'(exp_out.prs1), "prs1");
            check_value(int'(renamed.prs2), int'(exp_out.prs2), "prs2");
            check_value(int'(renamed.pdst), int'(exp_out.pdst), "pdst");
            check_value(int'(renamed.old_pdst), int'(exp_out.old_pdst), "old_pdst");
            check_value(int'(renamed.checkpoint), int'(exp_out.checkpoint), "checkpoint label");
            check_value(int'(renamed.has_checkpoint), int'(exp_out.has_checkpoint),
                        "has_checkpoint");
            if (file_pdst != NO_CHECK) begin
                check_value(int'(renamed.pdst), file_pdst, "pdst vs data file");
            end
        end else begin
            check_value(int'(out_valid), 0, "out_valid_o without accepted request");
        end
        #1;
    endtask

    initial begin
        int    fd;
        int    n;
        int    lines;
        int    cycles;
        int    f [15];  // rep valid rs1 rs2 rd wr ckpt rec label fv fp rel stall ooc pdst
        string text;
        cycles         = 0;
        rstn           = 1'b0;
        req            = '0;
        checkpoint_req = 1'b0;
        recover        = 1'b0;
        recover_label  = '0;
        free_valid     = 1'b0;
        free_preg      = '0;
        release_ckpt   = 1'b0;
        reset_model();
        repeat (4) @(posedge clk);
        #2;
        rstn = 1'b1;
        @(posedge clk);
        #2;

        fd = $fopen("verification/rename_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verification/rename_testdata.txt");
        end
        lines = 0;
        while (!$feof(fd) && (lines < MAX_LINES)) begin
            lines++;
            n = $fgets(text, fd);
            if ((n == 0) || (text.len() < 2) || (text.getc(0) == "#")) begin
                continue;  // Blank or column comment
            end
            n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                        f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
            if (n != 15) begin
                abort_run($sformatf("data line %0d does not have 15 columns", lines));
            end
            req.valid      = f[1][0];
            req.rs1        = arch_reg_t'(f[2]);
            req.rs2        = arch_reg_t'(f[3]);
            req.rd         = arch_reg_t'(f[4]);
            req.writes_rd  = f[5][0];
            checkpoint_req = f[6][0];
            recover        = f[7][0];
            recover_label  = checkpoint_t'(f[8]);
            free_valid     = f[9][0];
            free_preg      = phys_reg_t'(f[10]);
            release_ckpt   = f[11][0];
            // Repeated lines check pdst only through the model
            for (int k = 0; k < f[0]; k++) begin
                run_cycle(f[12], f[13], (f[0] == 1) ? f[14] : NO_CHECK);
                cycles++;
            end
        end
        $fclose(fd);
        req            = '0;
        checkpoint_req = 1'b0;
        recover        = 1'b0;
        free_valid     = 1'b0;
        release_ckpt   = 1'b0;

        if (cycles == 0) begin
            abort_run("data file holds no commands");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== source/rename_top.sv ====
// Top of the register rename stage, ties request stage, free list and rename table together
`timescale 1ns/1ps
`default_nettype none

module rename_top
    import isa_pkg::*, rename_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rstn_i,
    input  wire rename_req_t req_i,                 // One decoded instruction per cycle
    input  wire logic        checkpoint_req_i,      // Branch checkpoint strobe
    input  wire logic        recover_i,             // Mispredict, restore recover_label_i
    input  wire checkpoint_t recover_label_i,
    input  wire logic        free_valid_i,          // Commit frees free_preg_i
    input  wire phys_reg_t   free_preg_i,
    input  wire logic        release_checkpoint_i,  // Oldest branch resolved correctly
    output renamed_instr_t   renamed_o,
    output logic             out_valid_o,
    output logic             rename_stall_o,
    output logic             out_of_checkpoints_o
);

    rename_cmd_t cmd;
    logic        free_empty;
    logic        out_of_ckpt;
    phys_reg_t   alloc_preg;
    checkpoint_t ckpt_label;   // Shared label for map and head snapshot

    rename_request u_request (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .req_i                (req_i),
        .checkpoint_req_i     (checkpoint_req_i),
        .recover_i            (recover_i),
        .free_empty_i         (free_empty),
        .out_of_checkpoints_i (out_of_ckpt),
        .cmd_o                (cmd),
        .stall_o              (rename_stall_o)
    );

    free_list u_free_list (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .cmd_i              (cmd),
        .checkpoint_label_i (ckpt_label),
        .recover_i          (recover_i),
        .recover_label_i    (recover_label_i),
        .free_valid_i       (free_valid_i),
        .free_preg_i        (free_preg_i),
        .alloc_preg_o       (alloc_preg),
        .empty_o            (free_empty)
    );

    rename_table u_rename_table (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .cmd_i                (cmd),
        .new_dst_i            (alloc_preg),
        .recover_i            (recover_i),
        .recover_label_i      (recover_label_i),
        .release_checkpoint_i (release_checkpoint_i),
        .renamed_o            (renamed_o),
        .out_valid_o          (out_valid_o),
        .checkpoint_label_o   (ckpt_label),
        .out_of_checkpoints_o (out_of_ckpt)
    );

    assign out_of_checkpoints_o = out_of_ckpt;  // Also feeds the stall decision

endmodule

`default_nettype wire

// ==== source/rename_table.sv ====
// Versioned architectural-to-physical map with checkpoint copy, recovery and registered rename output
`timescale 1ns/1ps
`default_nettype none
`include "rename_params.svh"

module rename_table
    import rename_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rstn_i,
    input  wire rename_cmd_t cmd_i,
    input  wire phys_reg_t   new_dst_i,             // Free-list head for this allocation
    input  wire logic        recover_i,
    input  wire checkpoint_t recover_label_i,
    input  wire logic        release_checkpoint_i,  // Oldest checkpoint resolved
    output renamed_instr_t   renamed_o,
    output logic             out_valid_o,
    output checkpoint_t      checkpoint_label_o,    // Working version the free list snapshots under
    output logic             out_of_checkpoints_o
);

    localparam int NUM_ARCH = `RENAME_NUM_ARCH_REGS;
    localparam int NUM_CKPT = `RENAME_NUM_CHECKPOINTS;
    localparam int CNT_W    = $clog2(NUM_CKPT) + 1;  // Counts 0..NUM_CKPT-1 with headroom

    phys_reg_t   map_q [NUM_CKPT][NUM_ARCH];  // One full map per version
    checkpoint_t ver_head_q;                  // Working version
    checkpoint_t ver_tail_q;                  // Oldest live checkpoint
    checkpoint_t ver_tail_nxt;
    checkpoint_t ver_write;                   // Version taking this cycle's write
    logic [CNT_W-1:0] num_ckpt_q;             // Live checkpoints
    logic        release_en;
    phys_reg_t   src1_map;
    phys_reg_t   src2_map;
    phys_reg_t   dst_map;

    // Reads see the map before this instruction's own write
    assign src1_map = map_q[ver_head_q][cmd_i.rs1];
    assign src2_map = map_q[ver_head_q][cmd_i.rs2];
    assign dst_map  = map_q[ver_head_q][cmd_i.rd];

    // Ignore a release with nothing live
    assign release_en   = release_checkpoint_i & (num_ckpt_q != '0);
    assign ver_tail_nxt = checkpoint_t'(ver_tail_q + checkpoint_t'(release_en));

    // Checkpoint freezes the current version and moves on to the next
    assign ver_write = cmd_i.do_checkpoint ? checkpoint_t'(ver_head_q + checkpoint_t'(1))
                                           : ver_head_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ver_head_q  <= '0;
            ver_tail_q  <= '0;
            num_ckpt_q  <= '0;
            out_valid_o <= 1'b0;
            // Every version starts as identity with version 0 working
            for (int v = 0; v < NUM_CKPT; v++) begin
                for (int r = 0; r < NUM_ARCH; r++) begin
                    map_q[v][r] <= phys_reg_t'(r);
                end
            end
        end else begin
            ver_tail_q  <= ver_tail_nxt;      // Release also acts during recover
            out_valid_o <= cmd_i.do_rename;  // Low after a recover cycle

            if (recover_i) begin
                // Version L becomes working again, so it no longer counts as live
                ver_head_q <= recover_label_i;
                num_ckpt_q <= CNT_W'(checkpoint_t'(recover_label_i - ver_tail_nxt));
            end else begin
                num_ckpt_q <= num_ckpt_q + CNT_W'(cmd_i.do_checkpoint) - CNT_W'(release_en);

                if (cmd_i.do_checkpoint) begin
                    for (int r = 0; r < NUM_ARCH; r++) begin
                        map_q[ver_write][r] <= map_q[ver_head_q][r];  // Copy working map
                    end
                    ver_head_q <= ver_write;
                end

                // Placed after the copy so the new mapping wins
                if (cmd_i.alloc_dst) begin
                    map_q[ver_write][cmd_i.rd] <= new_dst_i;
                end
            end
        end
    end

    // Renamed fields are qualified by out_valid_o
    always_ff @(posedge clk_i) begin
        if (cmd_i.do_rename) begin
            renamed_o.prs1           <= src1_map;
            renamed_o.prs2           <= src2_map;
            renamed_o.pdst           <= cmd_i.alloc_dst ? new_dst_i : dst_map;
            renamed_o.old_pdst       <= dst_map;
            renamed_o.checkpoint     <= ver_head_q;  // Frozen version is the recover label
            renamed_o.has_checkpoint <= cmd_i.do_checkpoint;
        end
    end

    assign checkpoint_label_o = ver_head_q;

    // One version must stay free as the working copy
    assign out_of_checkpoints_o = (num_ckpt_q == CNT_W'(NUM_CKPT - 1));

endmodule

`default_nettype wire

// ==== source/free_list.sv ====
// Circular free list of physical registers, popped at rename, pushed at commit, head restored on recover
`timescale 1ns/1ps
`default_nettype none
`include "rename_params.svh"

module free_list
    import rename_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rstn_i,
    input  wire rename_cmd_t cmd_i,               // Alloc and checkpoint strobes
    input  wire checkpoint_t checkpoint_label_i,  // Working version label of the table
    input  wire logic        recover_i,
    input  wire checkpoint_t recover_label_i,
    input  wire logic        free_valid_i,        // Commit returns a register
    input  wire phys_reg_t   free_preg_i,
    output phys_reg_t        alloc_preg_o,        // Register for the current allocation
    output logic             empty_o
);

    // Only the registers beyond the architectural set can ever be free
    localparam int FL_DEPTH = `RENAME_NUM_PHYS_REGS - `RENAME_NUM_ARCH_REGS;
    localparam int IDX_W    = $clog2(FL_DEPTH);
    localparam int PTR_W    = IDX_W + 1;  // Extra wrap bit, tail minus head gives 0..DEPTH

    phys_reg_t        fl_mem [FL_DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W-1:0] count_q;
    logic [PTR_W-1:0] head_snap [`RENAME_NUM_CHECKPOINTS];  // Head per checkpoint label
    logic [PTR_W-1:0] tail_nxt;
    logic [PTR_W-1:0] snap_head;
    logic             pop;
    logic             push;

    assign pop  = cmd_i.alloc_dst;  // Already blocked on empty by the request stage
    assign push = free_valid_i;

    // Commit keeps pushing during recover, so count uses the new tail
    assign tail_nxt  = tail_q + PTR_W'(push);
    assign snap_head = head_snap[recover_label_i];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= PTR_W'(FL_DEPTH);  // Full, wrapped once
            count_q <= PTR_W'(FL_DEPTH);
            // p32..p63 in order, p0..p31 hold the identity map
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_mem[i] <= phys_reg_t'(`RENAME_NUM_ARCH_REGS + i);
            end
        end else begin
            if (push) begin
                fl_mem[tail_q[IDX_W-1:0]] <= free_preg_i;
            end
            tail_q <= tail_nxt;

            if (recover_i) begin
                // Registers popped after the checkpoint are handed out again
                head_q  <= snap_head;
                count_q <= tail_nxt - snap_head;
            end else begin
                head_q  <= head_q + PTR_W'(pop);
                count_q <= count_q + PTR_W'(push) - PTR_W'(pop);
            end
        end
    end

    // Head as it was before the checkpointing instruction allocates
    always_ff @(posedge clk_i) begin
        if (cmd_i.do_checkpoint) begin
            head_snap[checkpoint_label_i] <= head_q;
        end
    end

    assign alloc_preg_o = fl_mem[head_q[IDX_W-1:0]];  // Head entry, popped on alloc
    assign empty_o      = (count_q == '0);

endmodule

`default_nettype wire

// ==== source/rename_request.sv ====
// Input side of renaming, turns the raw request and strobes into a command and a stall level
`timescale 1ns/1ps
`default_nettype none

module rename_request
    import isa_pkg::*, rename_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rstn_i,
    input  wire rename_req_t req_i,                 // Decoded instruction
    input  wire logic        checkpoint_req_i,      // Branch wants a checkpoint
    input  wire logic        recover_i,             // Mispredict recovery this cycle
    input  wire logic        free_empty_i,          // No free physical register
    input  wire logic        out_of_checkpoints_i,  // All spare versions in use
    output rename_cmd_t      cmd_o,
    output logic             stall_o
);

    logic pending_recover_q;  // Cycle right after a recovery
    logic needs_alloc;
    logic alloc_stall;
    logic ckpt_stall;
    logic pending_stall;
    logic go;

    // rd of x0 or no write means nothing to allocate
    assign needs_alloc = req_i.valid & req_i.writes_rd & (req_i.rd != ZERO_REG);

    assign alloc_stall   = needs_alloc & free_empty_i;
    assign ckpt_stall    = checkpoint_req_i & out_of_checkpoints_i;
    // Source must hold its request over the settle cycle
    assign pending_stall = pending_recover_q & (req_i.valid | checkpoint_req_i);

    // Recovery wins over everything, stall stays low then
    assign stall_o = ~recover_i & (alloc_stall | ckpt_stall | pending_stall);

    assign go = ~recover_i & ~pending_recover_q & ~alloc_stall & ~ckpt_stall;

    always_comb begin
        cmd_o               = '0;
        cmd_o.rs1           = req_i.rs1;  // Indices pass through, actions are gated
        cmd_o.rs2           = req_i.rs2;
        cmd_o.rd            = req_i.rd;
        cmd_o.do_rename     = req_i.valid & go;
        cmd_o.alloc_dst     = needs_alloc & go;
        cmd_o.do_checkpoint = checkpoint_req_i & req_i.valid & go;  // Only with an instruction
    end

    // Map and free-list head settle on the recovered version
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pending_recover_q <= 1'b0;
        end else begin
            pending_recover_q <= recover_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/rename_pkg.sv ====
// Physical-side types of the rename stage, shared by the request stage, free list and table
`default_nettype none

package rename_pkg;

    `include "rename_params.svh"

    import isa_pkg::*;

    // Physical register index
    typedef logic [$clog2(`RENAME_NUM_PHYS_REGS)-1:0] phys_reg_t;

    // Map version label, also used as checkpoint tag
    typedef logic [$clog2(`RENAME_NUM_CHECKPOINTS)-1:0] checkpoint_t;

    // Qualified command from the request stage
    // All action bits low when stalled or recovering
    typedef struct packed {
        logic      do_rename;      // Produce a renamed instruction
        logic      alloc_dst;      // Pop a free register for rd
        logic      do_checkpoint;  // Snapshot map and free-list head first
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
    } rename_cmd_t;

    // Renamed instruction leaving the stage
    typedef struct packed {
        phys_reg_t   prs1;            // Mapping of rs1
        phys_reg_t   prs2;            // Mapping of rs2
        phys_reg_t   pdst;            // New mapping of rd, or current one if no alloc
        phys_reg_t   old_pdst;        // Mapping replaced, freed at commit
        checkpoint_t checkpoint;      // Label to recover to on mispredict
        logic        has_checkpoint;  // Label valid for this instruction
    } renamed_instr_t;

endpackage

`default_nettype wire

// ==== source/isa_pkg.sv ====
// Architectural view of an instruction as it reaches renaming, imported by the request stage
`default_nettype none

package isa_pkg;

    `include "rename_params.svh"

    // Architectural register index, 5 bits for RV32I/RV64I
    typedef logic [$clog2(`RENAME_NUM_ARCH_REGS)-1:0] arch_reg_t;

    // x0 is hardwired to zero and never gets a new mapping
    localparam arch_reg_t ZERO_REG = '0;

    // Decoded instruction handed to the rename stage
    typedef struct packed {
        logic      valid;      // Instruction present this cycle
        arch_reg_t rs1;        // First source
        arch_reg_t rs2;        // Second source
        arch_reg_t rd;         // Destination
        logic      writes_rd;  // Instruction writes a result
    } rename_req_t;

endpackage

`default_nettype wire

// ==== source/rename_params.svh ====
// Register counts and checkpoint depth of the rename stage, included by packages, RTL and testbench
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Architectural integer registers, x0 included
`define RENAME_NUM_ARCH_REGS 32

// Physical register file size
// Everything above the architectural count starts on the free list
`define RENAME_NUM_PHYS_REGS 64

// Map versions kept by the rename table
// One is always the working copy, so three can be live checkpoints
`define RENAME_NUM_CHECKPOINTS 4

`endif
